// File: Bender.yml
package:
  name: tile_noc

sources:
  # packages first, tile_cfg_pkg depends on noc_flit_pkg
  - files:
      - logic/noc_flit_pkg.sv
      - logic/tile_cfg_pkg.sv
      - logic/tile_reset_gate.sv
      - logic/irq_sync.sv
      - logic/wr_req_capture.sv
      - logic/wr_req_fifo.sv
      - logic/noc_write_serializer.sv
      - logic/tile_noc_top.sv
  - target: simulation
    files:
      - tb/tb_tile_noc.sv

// File: logic/irq_sync.sv
/*
  Two-flop synchronizers for the asynchronous interrupt and debug levels.
  Each output follows its input two clock edges later.
*/
`timescale 1ns/1ps

module irq_sync (
  input  logic       clk_i,
  input  logic       reset_l,
  input  logic [1:0] irq_i,
  input  logic       ipi_i,
  input  logic       time_irq_i,
  input  logic       debug_req_i,
  output logic [1:0] irq_o,
  output logic       ipi_o,
  output logic       time_irq_o,
  output logic       debug_req_o
);

  // all five lines share one pair of stages
  logic [4:0] lines;
  logic [4:0] meta_q;
  logic [4:0] sync_q;

  assign lines = {irq_i, ipi_i, time_irq_i, debug_req_i};

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= lines;
      sync_q <= meta_q;
    end
  end

  // unpack in the same order
  assign {irq_o, ipi_o, time_irq_o, debug_req_o} = sync_q;

endmodule

// File: logic/noc_flit_pkg.sv
/*
  Network flit layout for the outbound request channel. Holds field widths,
  message codes and the packed records that travel down the write chain.
  Compile this package before tile_cfg_pkg, which sizes its fields from it.
*/
package noc_flit_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int noc_data_width   = 64;
  localparam int phys_addr_width  = 40;
  localparam int noc_strb_width   = noc_data_width / 8;
  // header field widths, openpiton layout
  localparam int noc_chipid_width = 14;
  localparam int noc_x_width      = 8;
  localparam int noc_y_width      = 8;
  localparam int noc_fbits_width  = 4;
  localparam int msg_len_width    = 8;
  localparam int msg_type_width   = 8;
  localparam int msg_tag_width    = 8;

  // store request message code
  localparam logic [msg_type_width-1:0] msg_write = 8'd15;
  // flits after the header: address, source, data
  localparam logic [msg_len_width-1:0]  req_len   = 8'd3;

  ////////////////////////////////////////////////////////////////////////////
  // records
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [noc_chipid_width-1:0] chipid;
    logic [noc_x_width-1:0]      xpos;
    logic [noc_y_width-1:0]      ypos;
  } noc_src_id_t;

  // lite write request as it arrives
  typedef struct packed {
    logic [phys_addr_width-1:0] addr;
    logic [noc_data_width-1:0]  data;
    logic [noc_strb_width-1:0]  strb;
  } wr_req_t;

  // queued record, address already aligned
  typedef struct packed {
    logic [msg_tag_width-1:0]   tag;
    logic [phys_addr_width-1:0] addr;
    logic [noc_data_width-1:0]  data;
    logic [noc_strb_width-1:0]  strb;
  } wr_rec_t;

  // header flit, msb first; low six bits stay zero
  typedef struct packed {
    logic [noc_chipid_width-1:0] dst_chipid;
    logic [noc_x_width-1:0]      dst_xpos;
    logic [noc_y_width-1:0]      dst_ypos;
    logic [noc_fbits_width-1:0]  fbits;
    logic [msg_len_width-1:0]    len;
    logic [msg_type_width-1:0]   msg_type;
    logic [msg_tag_width-1:0]    tag;
    logic [5:0]                  rsvd;
  } noc_hdr_t;

endpackage

// File: logic/noc_write_serializer.sv
/*
  Turns each queued write record into four request flits on the outbound
  network channel: header, address with strobe, source, data.
  A flit holds steady until the network takes it.
*/
`timescale 1ns/1ps

module noc_write_serializer (
  input  logic                                    clk_i,
  input  logic                                    tile_rst_l_i,
  input  logic                                    empty_i,
  input  noc_flit_pkg::wr_rec_t                   rec_i,
  output logic                                    pop_o,
  input  noc_flit_pkg::noc_src_id_t               src_id_i,
  output logic                                    noc2_valid_o,
  output logic [noc_flit_pkg::noc_data_width-1:0] noc2_data_o,
  input  logic                                    noc2_ready_i
);

  // zero fill above the strobe and below the source fbits
  localparam int addr_pad = noc_flit_pkg::noc_data_width - noc_flit_pkg::phys_addr_width
                          - noc_flit_pkg::noc_strb_width;
  localparam int src_pad  = noc_flit_pkg::noc_data_width
                          - $bits(noc_flit_pkg::noc_src_id_t)
                          - noc_flit_pkg::noc_fbits_width;

  logic                  busy_q;
  logic [1:0]            flit_cnt_q;
  logic                  flit_acc;
  logic                  last_acc;
  noc_flit_pkg::wr_rec_t rec_q;
  noc_flit_pkg::noc_hdr_t hdr;

  assign flit_acc = busy_q & noc2_ready_i;
  assign last_acc = flit_acc & (flit_cnt_q == 2'd3);
  // next record as the last flit goes, or when idle
  assign pop_o = ~empty_i & (~busy_q | last_acc);
  assign noc2_valid_o = busy_q;

  ////////////////////////////////////////////////////////////////////////////
  // flit sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge tile_rst_l_i) begin
    if (!tile_rst_l_i) begin
      busy_q     <= 1'b0;
      flit_cnt_q <= 2'd0;
    end else begin
      if (pop_o) begin
        busy_q     <= 1'b1;
        flit_cnt_q <= 2'd0;
      end else if (last_acc) begin
        busy_q <= 1'b0;
      end else if (flit_acc) begin
        flit_cnt_q <= flit_cnt_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      rec_q <= rec_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // flit contents
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hdr            = '0;
    hdr.dst_chipid = tile_cfg_pkg::mem_chipid;
    hdr.dst_xpos   = tile_cfg_pkg::mem_xpos;
    hdr.dst_ypos   = tile_cfg_pkg::mem_ypos;
    hdr.fbits      = tile_cfg_pkg::fbits_mem;
    hdr.len        = noc_flit_pkg::req_len;
    hdr.msg_type   = noc_flit_pkg::msg_write;
    hdr.tag        = rec_q.tag;
  end

  always_comb begin
    case (flit_cnt_q)
      2'd0:    noc2_data_o = hdr;
      2'd1:    noc2_data_o = {{addr_pad{1'b0}}, rec_q.strb, rec_q.addr};
      2'd2:    noc2_data_o = {src_id_i, tile_cfg_pkg::fbits_tile, {src_pad{1'b0}}};
      default: noc2_data_o = rec_q.data;
    endcase
  end

endmodule

// File: logic/tile_cfg_pkg.sv
/*
  Where this tile sits on the network and where its writes go.
  Also holds the default sizes the top level hands to its submodules.
  Field widths come from noc_flit_pkg, so compile that package first.
*/
package tile_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // memory controller destination
  ////////////////////////////////////////////////////////////////////////////

  // off-chip memory, so top bit of chip id set
  localparam logic [noc_flit_pkg::noc_chipid_width-1:0] mem_chipid =
    {1'b1, {(noc_flit_pkg::noc_chipid_width-1){1'b0}}};
  localparam logic [noc_flit_pkg::noc_x_width-1:0]      mem_xpos   = '0;
  localparam logic [noc_flit_pkg::noc_y_width-1:0]      mem_ypos   = '0;

  ////////////////////////////////////////////////////////////////////////////
  // final routing codes
  ////////////////////////////////////////////////////////////////////////////

  // memory port on the destination router
  localparam logic [noc_flit_pkg::noc_fbits_width-1:0] fbits_mem  = 4'b0010;
  // vector tile port, returned in the source flit
  localparam logic [noc_flit_pkg::noc_fbits_width-1:0] fbits_tile = 4'b0110;

  ////////////////////////////////////////////////////////////////////////////
  // default sizes
  ////////////////////////////////////////////////////////////////////////////

  // top bit after 32k cycles, enough for on-chip sram init
  localparam int wake_cnt_width_default = 16;
  // queued write records
  localparam int fifo_depth_default     = 4;

endpackage

// File: logic/tile_noc_top.sv
/*
  Network interface of the vector tile. Gates the wake-up reset,
  synchronizes the interrupt lines and runs the write chain from the lite
  request port to the outbound request channel.
*/
`timescale 1ns/1ps

module tile_noc_top #(
  parameter int wake_cnt_width = tile_cfg_pkg::wake_cnt_width_default,
  parameter int fifo_depth     = tile_cfg_pkg::fifo_depth_default
) (
  input  logic                                    clk_i,
  input  logic                                    reset_l,
  output logic                                    tile_rst_l_o,
  // interrupts, async in, synced out
  input  logic [1:0]                              irq_i,
  input  logic                                    ipi_i,
  input  logic                                    time_irq_i,
  input  logic                                    debug_req_i,
  output logic [1:0]                              irq_o,
  output logic                                    ipi_o,
  output logic                                    time_irq_o,
  output logic                                    debug_req_o,
  // own network coordinates
  input  noc_flit_pkg::noc_src_id_t               src_id_i,
  // lite write request
  input  logic                                    wr_valid_i,
  input  noc_flit_pkg::wr_req_t                   wr_req_i,
  output logic                                    wr_ready_o,
  // outbound request channel
  output logic                                    noc2_valid_o,
  output logic [noc_flit_pkg::noc_data_width-1:0] noc2_data_o,
  input  logic                                    noc2_ready_i
);

  logic                  tile_rst_l;
  logic                  push;
  logic                  pop;
  logic                  fifo_full;
  logic                  fifo_empty;
  noc_flit_pkg::wr_rec_t cap_rec;
  noc_flit_pkg::wr_rec_t head_rec;

  assign tile_rst_l_o = tile_rst_l;

  ////////////////////////////////////////////////////////////////////////////
  // reset and interrupts
  ////////////////////////////////////////////////////////////////////////////

  tile_reset_gate #(
    .wake_cnt_width (wake_cnt_width)
  ) u_rst_gate (
    .clk_i        (clk_i),
    .reset_l      (reset_l),
    .tile_rst_l_o (tile_rst_l)
  );

  irq_sync u_irq_sync (
    .clk_i       (clk_i),
    .reset_l     (reset_l),
    .irq_i       (irq_i),
    .ipi_i       (ipi_i),
    .time_irq_i  (time_irq_i),
    .debug_req_i (debug_req_i),
    .irq_o       (irq_o),
    .ipi_o       (ipi_o),
    .time_irq_o  (time_irq_o),
    .debug_req_o (debug_req_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // write chain, all on the gated reset
  ////////////////////////////////////////////////////////////////////////////

  wr_req_capture u_capture (
    .clk_i        (clk_i),
    .tile_rst_l_i (tile_rst_l),
    .wr_valid_i   (wr_valid_i),
    .wr_req_i     (wr_req_i),
    .wr_ready_o   (wr_ready_o),
    .fifo_full_i  (fifo_full),
    .push_o       (push),
    .rec_o        (cap_rec)
  );

  wr_req_fifo #(
    .fifo_depth (fifo_depth)
  ) u_fifo (
    .clk_i        (clk_i),
    .tile_rst_l_i (tile_rst_l),
    .push_i       (push),
    .rec_i        (cap_rec),
    .full_o       (fifo_full),
    .pop_i        (pop),
    .empty_o      (fifo_empty),
    .rec_o        (head_rec)
  );

  noc_write_serializer u_serializer (
    .clk_i        (clk_i),
    .tile_rst_l_i (tile_rst_l),
    .empty_i      (fifo_empty),
    .rec_i        (head_rec),
    .pop_o        (pop),
    .src_id_i     (src_id_i),
    .noc2_valid_o (noc2_valid_o),
    .noc2_data_o  (noc2_data_o),
    .noc2_ready_i (noc2_ready_i)
  );

endmodule

// File: logic/tile_reset_gate.sv
/*
  Holds the tile in reset after the external reset is released, so that
  on-chip memories finish their init, then synchronizes the release.
  Assertion of reset passes straight through.
*/
`timescale 1ns/1ps

module tile_reset_gate #(
  parameter int wake_cnt_width
) (
  input  logic clk_i,
  input  logic reset_l,
  output logic tile_rst_l_o
);

  ////////////////////////////////////////////////////////////////////////////
  // wake-up counter
  ////////////////////////////////////////////////////////////////////////////

  logic [wake_cnt_width-1:0] wake_cnt_d;
  logic [wake_cnt_width-1:0] wake_cnt_q;
  logic                      gate_l;
  logic                      sync_q1;
  logic                      sync_q2;

  // saturate once the top bit is set
  assign wake_cnt_d = wake_cnt_q[wake_cnt_width-1] ? wake_cnt_q : wake_cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      wake_cnt_q <= '0;
    end else begin
      wake_cnt_q <= wake_cnt_d;
    end
  end

  // gated reset before sync
  assign gate_l = wake_cnt_q[wake_cnt_width-1] & reset_l;

  ////////////////////////////////////////////////////////////////////////////
  // reset synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // async assert, two-flop release
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= gate_l;
      sync_q2 <= sync_q1;
    end
  end

  assign tile_rst_l_o = sync_q2;

endmodule

// File: logic/wr_req_capture.sv
/*
  Accepts lite write requests one at a time, aligns the address to the
  flit and tags each request, then hands the record to the queue.
  A held record blocks new requests until the queue takes it.
*/
`timescale 1ns/1ps

module wr_req_capture (
  input  logic                  clk_i,
  input  logic                  tile_rst_l_i,
  input  logic                  wr_valid_i,
  input  noc_flit_pkg::wr_req_t wr_req_i,
  output logic                  wr_ready_o,
  input  logic                  fifo_full_i,
  output logic                  push_o,
  output noc_flit_pkg::wr_rec_t rec_o
);

  // byte offset bits inside one flit
  localparam int off_bits = $clog2(noc_flit_pkg::noc_strb_width);

  logic                                   active_q;
  logic                                   full_q;
  logic                                   accept;
  logic [noc_flit_pkg::msg_tag_width-1:0] tag_q;
  noc_flit_pkg::wr_rec_t                  rec_q;

  // hand off whenever the queue has room
  assign push_o = full_q & ~fifo_full_i;
  // empty, or emptying this cycle
  assign wr_ready_o = active_q & (~full_q | push_o);
  assign accept = wr_valid_i & wr_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge tile_rst_l_i) begin
    if (!tile_rst_l_i) begin
      active_q <= 1'b0;
      full_q   <= 1'b0;
      tag_q    <= '0;
    end else begin
      active_q <= 1'b1;
      if (accept) begin
        full_q <= 1'b1;
        tag_q  <= tag_q + 1'b1;
      end else if (push_o) begin
        full_q <= 1'b0;
      end
    end
  end

  // payload, only loaded on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rec_q.tag  <= tag_q;
      rec_q.addr <= {wr_req_i.addr[noc_flit_pkg::phys_addr_width-1:off_bits],
                     {off_bits{1'b0}}};
      rec_q.data <= wr_req_i.data;
      rec_q.strb <= wr_req_i.strb;
    end
  end

  assign rec_o = rec_q;

endmodule

// File: logic/wr_req_fifo.sv
/*
  Circular buffer of tagged write records between capture and serializer.
  The head record is always visible on rec_o; pop advances past it.
*/
`timescale 1ns/1ps

module wr_req_fifo #(
  parameter int fifo_depth
) (
  input  logic                  clk_i,
  input  logic                  tile_rst_l_i,
  input  logic                  push_i,
  input  noc_flit_pkg::wr_rec_t rec_i,
  output logic                  full_o,
  input  logic                  pop_i,
  output logic                  empty_o,
  output noc_flit_pkg::wr_rec_t rec_o
);

  // pointer needs at least one bit
  localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_width = $clog2(fifo_depth + 1);

  noc_flit_pkg::wr_rec_t mem_q [fifo_depth];
  logic [ptr_width-1:0]  wr_ptr_q;
  logic [ptr_width-1:0]  rd_ptr_q;
  logic [cnt_width-1:0]  count_q;
  logic                  do_push;
  logic                  do_pop;

  assign full_o  = (count_q == cnt_width'(fifo_depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  ////////////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge tile_rst_l_i) begin
    if (!tile_rst_l_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // wrap at depth, not at a power of two
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leave count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

  assign rec_o = mem_q[rd_ptr_q];

endmodule

// File: tb/tb_tile_noc.sv
/*
  Testbench for the tile network interface. Runs reset gating, interrupt
  sync and the write path to the outbound channel against a queue model.
  Run from the project root with vlog.f, top module tb_tile_noc.
*/
`timescale 1ns/1ps

module tb_tile_noc;

  localparam int fifo_depth = 4;
  // ~450 cycles of tests in all, so this is well clear of a normal run
  localparam int cycle_limit = 2000;
  localparam int n_random = 20;

  logic                           clk_i;
  logic                           reset_l;
  logic                           tile_rst_l_o;
  logic [1:0]                     irq_i;
  logic                           ipi_i;
  logic                           time_irq_i;
  logic                           debug_req_i;
  logic [1:0]                     irq_o;
  logic                           ipi_o;
  logic                           time_irq_o;
  logic                           debug_req_o;
  noc_flit_pkg::noc_src_id_t      src_id_i;
  logic                           wr_valid_i;
  noc_flit_pkg::wr_req_t          wr_req_i;
  logic                           wr_ready_o;
  logic                           noc2_valid_o;
  logic [63:0]                    noc2_data_o;
  logic                           noc2_ready_i;

  int                             seed = 58904;
  int                             err_count = 0;
  int                             tests_ok = 0;
  int                             tests_bad = 0;
  int                             cycles = 0;
  int                             flits_seen = 0;
  int                             flit_idx = 0;
  logic [7:0]                     next_tag = '0;
  bit                             random_ready = 0;
  noc_flit_pkg::wr_rec_t          exp_q[$];

  tile_noc_top #(
    .wake_cnt_width (4),
    .fifo_depth     (fifo_depth)
  ) dut0 (
    .clk_i        (clk_i),
    .reset_l      (reset_l),
    .tile_rst_l_o (tile_rst_l_o),
    .irq_i        (irq_i),
    .ipi_i        (ipi_i),
    .time_irq_i   (time_irq_i),
    .debug_req_i  (debug_req_i),
    .irq_o        (irq_o),
    .ipi_o        (ipi_o),
    .time_irq_o   (time_irq_o),
    .debug_req_o  (debug_req_o),
    .src_id_i     (src_id_i),
    .wr_valid_i   (wr_valid_i),
    .wr_req_i     (wr_req_i),
    .wr_ready_o   (wr_ready_o),
    .noc2_valid_o (noc2_valid_o),
    .noc2_data_o  (noc2_data_o),
    .noc2_ready_i (noc2_ready_i)
  );

  always #4 clk_i = ~clk_i;

  // hard stop if the DUT never drains
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // random back-pressure, only this process draws numbers while active
  always @(negedge clk_i) begin
    if (random_ready) begin
      noc2_ready_i = $random(seed);
    end
  end

  task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    err_count++;
  endtask

  // expected flit rebuilt from the record and the network layout
  function automatic logic [63:0] build_flit(input noc_flit_pkg::wr_rec_t rec, input int idx);
    noc_flit_pkg::noc_hdr_t hdr;
    logic [63:0]            flit;
    hdr            = '0;
    hdr.dst_chipid = tile_cfg_pkg::mem_chipid;
    hdr.dst_xpos   = tile_cfg_pkg::mem_xpos;
    hdr.dst_ypos   = tile_cfg_pkg::mem_ypos;
    hdr.fbits      = tile_cfg_pkg::fbits_mem;
    hdr.len        = 8'd3;
    hdr.msg_type   = noc_flit_pkg::msg_write;
    hdr.tag        = rec.tag;
    case (idx)
      0:       flit = hdr;
      1:       flit = {16'h0000, rec.strb, rec.addr};
      2:       flit = {src_id_i, tile_cfg_pkg::fbits_tile, 30'd0};
      default: flit = rec.data;
    endcase
    return flit;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    noc_flit_pkg::wr_rec_t rec;
    logic [63:0]           exp;
    if (wr_valid_i && wr_ready_o) begin
      rec.tag  = next_tag;
      rec.addr = {wr_req_i.addr[39:3], 3'b000};
      rec.data = wr_req_i.data;
      rec.strb = wr_req_i.strb;
      exp_q.push_back(rec);
      next_tag++;
    end
    if (noc2_valid_o && noc2_ready_i) begin
      // every handshake, expected or not
      flits_seen++;
      if (exp_q.size() == 0) begin
        $display("error at %0t: flit sent with no write outstanding", $time);
        err_count++;
      end else begin
        exp = build_flit(exp_q[0], flit_idx);
        assert (noc2_data_o == exp) else value_error("noc2_data_o", exp, noc2_data_o);
        if (flit_idx == 3) begin
          void'(exp_q.pop_front());
          flit_idx = 0;
        end else begin
          flit_idx++;
        end
      end
    end
  end

  // write path silent until the gated reset lifts
  reset_quiet_chk: assert property (@(posedge clk_i)
    !tile_rst_l_o |-> (!wr_ready_o && !noc2_valid_o))
    else begin
      $display("error at %0t: write path active while tile held in reset", $time);
      err_count++;
    end

  // stalled flit must hold
  flit_hold_chk: assert property (@(posedge clk_i) disable iff (!tile_rst_l_o)
    (noc2_valid_o && !noc2_ready_i) |=> (noc2_valid_o && $stable(noc2_data_o)))
    else begin
      $display("error at %0t: outbound flit changed or dropped while stalled", $time);
      err_count++;
    end

  task automatic end_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  // hold valid until taken or max_wait edges pass
  task automatic send_write(input noc_flit_pkg::wr_req_t req, input int max_wait,
                            output bit taken);
    int waited;
    waited     = 0;
    taken      = 0;
    wr_valid_i = 1'b1;
    wr_req_i   = req;
    while (!taken && waited < max_wait) begin
      @(posedge clk_i);
      taken = wr_ready_o;
      waited++;
    end
    @(negedge clk_i);
    wr_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || noc2_valid_o) begin
      @(negedge clk_i);
    end
  endtask

  function automatic noc_flit_pkg::wr_req_t random_req();
    noc_flit_pkg::wr_req_t req;
    req.addr = {$random(seed), $random(seed)};
    req.data = {$random(seed), $random(seed)};
    req.strb = $random(seed);
    return req;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    noc_flit_pkg::wr_req_t reqs[n_random];
    noc_flit_pkg::wr_req_t req;
    logic [4:0]            hist[32];
    bit                    taken;
    int                    errs;
    int                    flits0;
    int                    accepted;
    clk_i        = 1'b0;
    reset_l      = 1'b0;
    irq_i        = '0;
    ipi_i        = 1'b0;
    time_irq_i   = 1'b0;
    debug_req_i  = 1'b0;
    src_id_i     = {14'h0123, 8'h05, 8'h03};
    wr_valid_i   = 1'b0;
    wr_req_i     = '0;
    noc2_ready_i = 1'b1;
    repeat (4) @(negedge clk_i);

    // 1: tile reset rises 2^3 + 2 edges after release
    errs    = err_count;
    reset_l = 1'b1;
    for (int k = 1; k <= 12; k++) begin
      @(negedge clk_i);
      assert (tile_rst_l_o == (k >= 10))
        else value_error("tile_rst_l_o", 64'(k >= 10), 64'(tile_rst_l_o));
    end
    end_test("1 reset gate", errs);

    // 2: interrupt levels two edges later
    errs = err_count;
    for (int i = 0; i < 32; i++) begin
      if (i >= 2) begin
        assert ({irq_o, ipi_o, time_irq_o, debug_req_o} == hist[i-2])
          else value_error("irq_o/ipi_o/time_irq_o/debug_req_o", 64'(hist[i-2]),
                           64'({irq_o, ipi_o, time_irq_o, debug_req_o}));
      end
      hist[i] = $random(seed);
      {irq_i, ipi_i, time_irq_i, debug_req_i} = hist[i];
      @(negedge clk_i);
    end
    end_test("2 irq sync", errs);

    // 3: one unaligned write, no back-pressure
    errs     = err_count;
    flits0   = flits_seen;
    req.addr = 40'h12_3456_789d;
    req.data = 64'hdead_beef_0bad_f00d;
    req.strb = 8'hf0;
    send_write(req, 50, taken);
    wait_drain();
    assert (taken) else value_error("wr_ready_o", 64'd1, 64'd0);
    assert (flits_seen - flits0 == 4)
      else value_error("flit count", 64'd4, 64'(flits_seen - flits0));
    end_test("3 single write", errs);

    // 4: random writes under random back-pressure
    errs   = err_count;
    flits0 = flits_seen;
    for (int i = 0; i < n_random; i++) begin
      reqs[i] = random_req();
    end
    @(posedge clk_i);
    random_ready = 1;
    @(negedge clk_i);
    for (int i = 0; i < n_random; i++) begin
      send_write(reqs[i], 200, taken);
    end
    wait_drain();
    @(posedge clk_i);
    random_ready = 0;
    @(negedge clk_i);
    noc2_ready_i = 1'b1;
    assert (flits_seen - flits0 == 4 * n_random)
      else value_error("flit count", 64'(4 * n_random), 64'(flits_seen - flits0));
    end_test("4 random writes", errs);

    // 5: stalled channel, capture + fifo + serializer fill up
    errs         = err_count;
    flits0       = flits_seen;
    accepted     = 0;
    noc2_ready_i = 1'b0;
    for (int i = 0; i < 10; i++) begin
      send_write(random_req(), 12, taken);
      if (!taken) begin
        break;
      end
      accepted++;
    end
    assert (accepted == fifo_depth + 2)
      else value_error("accepted writes", 64'(fifo_depth + 2), 64'(accepted));
    noc2_ready_i = 1'b1;
    wait_drain();
    assert (flits_seen - flits0 == 4 * accepted)
      else value_error("flit count", 64'(4 * accepted), 64'(flits_seen - flits0));
    end_test("5 back-pressure", errs);

    $display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, err_count);
    if (tests_bad == 0 && err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
logic/noc_flit_pkg.sv
logic/tile_cfg_pkg.sv
logic/tile_reset_gate.sv
logic/irq_sync.sv
logic/wr_req_capture.sv
logic/wr_req_fifo.sv
logic/noc_write_serializer.sv
logic/tile_noc_top.sv
tb/tb_tile_noc.sv
